//--- rtl/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ==============================
// address split
// ==============================
`define ICACHE_ADDR_W      32
`define ICACHE_OFFSET_W    3
`define ICACHE_INDEX_W     8
`define ICACHE_TAG_W       21

// ==============================
// payload widths
// ==============================
`define ICACHE_INST_W      32
`define ICACHE_BLOCK_W     64
`define ICACHE_RESP_W      2

// geometry, two ways per set
`define ICACHE_SETS        256
`define ICACHE_BANK_W      2
`define ICACHE_BANKS       4
`define ICACHE_BANK_DEPTH  64
`define ICACHE_LINE_W      128

// addi x0, x0, 0
`define ICACHE_NOP         32'h00000013
`define ICACHE_RESP_OKAY   2'b00

`endif

//--- rtl/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // ==============================
    // FSM states
    // ==============================
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_HIT  = 2'd1,
        FETCH_MISS = 2'd2
    } fetch_state_e;

    typedef enum logic [1:0] {
        REFILL_IDLE = 2'd0,
        REFILL_ADDR = 2'd1,
        REFILL_DATA = 2'd2
    } refill_state_e;

    // ==============================
    // bundles
    // ==============================
    typedef struct packed {
        logic hit;
        logic way;
    } lookup_t;

    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_BLOCK_W-1:0] data;
        logic [`ICACHE_RESP_W-1:0]  resp;
        logic                       last;
    } axi_r_t;

    // one-cycle fill pulse from the refill engine
    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_ADDR_W-1:0]  addr;
        logic [`ICACHE_BLOCK_W-1:0] data;
        logic [`ICACHE_RESP_W-1:0]  resp;
    } fill_t;

endpackage

//--- rtl/icache_fetch_ctrl.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_fetch_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`ICACHE_ADDR_W-1:0]   fetch_pc,
    input  logic                        stall,
    input  logic                        flush,
    input  icache_pkg::lookup_t         lookup,
    input  icache_pkg::fill_t           fill,
    input  logic [`ICACHE_INST_W-1:0]   rd_inst,
    output logic [`ICACHE_ADDR_W-1:0]   lookup_addr,
    output logic                        miss_start,
    output logic [`ICACHE_ADDR_W-1:0]   miss_addr,
    output logic                        rd_en,
    output logic [`ICACHE_INDEX_W-1:0]  rd_index,
    output logic                        rd_way,
    output logic                        rd_word_hi,
    output logic [`ICACHE_INST_W-1:0]   inst,
    output logic                        inst_valid,
    output logic                        error
);

    icache_pkg::fetch_state_e state;
    logic                     flush_take;
    logic                     accept;
    logic                     hit_go;
    logic                     miss_go;
    // refill still running for a flushed miss
    logic                     dropped;
    logic                     word_hi_q;

    assign flush_take = flush & ~stall;
    assign accept     = (state == icache_pkg::FETCH_IDLE) & ~stall & ~flush & ~dropped;
    assign hit_go     = accept & lookup.hit;
    assign miss_go    = accept & ~lookup.hit;

    assign lookup_addr = fetch_pc;
    assign miss_start  = miss_go;
    assign miss_addr   = {fetch_pc[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    // hit read request, data comes back next cycle
    assign rd_en      = hit_go;
    assign rd_index   = fetch_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign rd_way     = lookup.way;
    assign rd_word_hi = fetch_pc[`ICACHE_OFFSET_W-1];

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || flush_take) begin
            state <= icache_pkg::FETCH_IDLE;
        end else begin
            case (state)
                icache_pkg::FETCH_IDLE: begin
                    if (hit_go)
                        state <= icache_pkg::FETCH_HIT;
                    else if (miss_go)
                        state <= icache_pkg::FETCH_MISS;
                end
                icache_pkg::FETCH_HIT: state <= icache_pkg::FETCH_IDLE;
                icache_pkg::FETCH_MISS: begin
                    if (fill.valid)
                        state <= icache_pkg::FETCH_IDLE;
                end
                default: state <= icache_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            dropped <= 1'b0;
        else if (fill.valid)
            dropped <= 1'b0;
        else if (flush_take && state == icache_pkg::FETCH_MISS)
            dropped <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (miss_go)
            word_hi_q <= fetch_pc[`ICACHE_OFFSET_W-1];
    end

    // ==============================
    // output register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || flush_take) begin
            inst       <= `ICACHE_NOP;
            inst_valid <= 1'b1;
        end else if (hit_go || miss_go) begin
            inst_valid <= 1'b0;
        end else if (state == icache_pkg::FETCH_HIT) begin
            inst       <= rd_inst;
            inst_valid <= 1'b1;
        end else if (state == icache_pkg::FETCH_MISS && fill.valid) begin
            inst       <= word_hi_q ? fill.data[`ICACHE_BLOCK_W-1 -: `ICACHE_INST_W]
                                    : fill.data[`ICACHE_INST_W-1:0];
            inst_valid <= 1'b1;
        end
    end

    // only delivered misses update the error level
    always_ff @(posedge clk) begin
        if (rst)
            error <= 1'b0;
        else if (state == icache_pkg::FETCH_MISS && fill.valid && !flush_take)
            error <= (fill.resp != `ICACHE_RESP_OKAY);
    end

    // a fill only answers the miss in flight, delivered or dropped
    fill_expected: assert property (
        @(posedge clk) disable iff (rst)
        fill.valid |-> (state == icache_pkg::FETCH_MISS) || dropped
    );

endmodule

//--- rtl/icache_tag_store.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tag_store (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_ADDR_W-1:0]  lookup_addr,
    input  icache_pkg::fill_t          fill,
    output icache_pkg::lookup_t        lookup,
    output logic                       fill_way
);

    logic [`ICACHE_TAG_W-1:0]   tag_q [2][`ICACHE_SETS];
    logic [1:0]                 valid_q [`ICACHE_SETS];
    logic                       victim_q [`ICACHE_SETS];

    logic [`ICACHE_INDEX_W-1:0] look_idx;
    logic [`ICACHE_TAG_W-1:0]   look_tag;
    logic [`ICACHE_INDEX_W-1:0] fill_idx;
    logic [`ICACHE_TAG_W-1:0]   fill_tag;
    logic                       hit0;
    logic                       hit1;

    assign look_idx = lookup_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign look_tag = lookup_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign fill_idx = fill.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign fill_tag = fill.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    // ==============================
    // compare, way 0 first
    // ==============================
    assign hit0 = valid_q[look_idx][0] && (tag_q[0][look_idx] == look_tag);
    assign hit1 = valid_q[look_idx][1] && (tag_q[1][look_idx] == look_tag);

    assign lookup.hit = hit0 | hit1;
    assign lookup.way = ~hit0 & hit1;

    // first invalid way, else the victim
    always_comb begin
        if (!valid_q[fill_idx][0])
            fill_way = 1'b0;
        else if (!valid_q[fill_idx][1])
            fill_way = 1'b1;
        else
            fill_way = victim_q[fill_idx];
    end

    // ==============================
    // fill update
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tag_q[0][s] <= '0;
                tag_q[1][s] <= '0;
                valid_q[s]  <= 2'b00;
                victim_q[s] <= 1'b0;
            end
        end else if (fill.valid) begin
            tag_q[fill_way][fill_idx]   <= fill_tag;
            valid_q[fill_idx][fill_way] <= 1'b1;
            // toggles on every fill
            victim_q[fill_idx]          <= ~victim_q[fill_idx];
        end
    end

    // a refill is only started for a block that missed in both ways
    ways_distinct: assert property (
        @(posedge clk) disable iff (rst)
        !(valid_q[look_idx] == 2'b11 && tag_q[0][look_idx] == tag_q[1][look_idx])
    );

endmodule

//--- rtl/icache_data_store.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_data_store (
    input  logic                        clk,
    input  icache_pkg::fill_t           fill,
    input  logic                        fill_way,
    input  logic                        rd_en,
    input  logic [`ICACHE_INDEX_W-1:0]  rd_index,
    input  logic                        rd_way,
    input  logic                        rd_word_hi,
    output logic [`ICACHE_INST_W-1:0]   rd_inst
);

    localparam int ROW_W = `ICACHE_INDEX_W - `ICACHE_BANK_W;

    // one line per set, way 1 in the upper half
    logic [`ICACHE_LINE_W-1:0]  bank_mem [`ICACHE_BANKS][`ICACHE_BANK_DEPTH];

    logic [`ICACHE_INDEX_W-1:0] fill_idx;
    logic [`ICACHE_BANK_W-1:0]  fill_bank;
    logic [ROW_W-1:0]           fill_row;
    logic [`ICACHE_LINE_W-1:0]  rd_line;
    logic [`ICACHE_BLOCK_W-1:0] rd_block;

    assign fill_idx  = fill.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign fill_bank = fill_idx[`ICACHE_INDEX_W-1 -: `ICACHE_BANK_W];
    assign fill_row  = fill_idx[ROW_W-1:0];

    // ==============================
    // lane write
    // ==============================
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            if (fill_way)
                bank_mem[fill_bank][fill_row][`ICACHE_LINE_W-1 -: `ICACHE_BLOCK_W] <= fill.data;
            else
                bank_mem[fill_bank][fill_row][`ICACHE_BLOCK_W-1:0] <= fill.data;
        end
    end

    // ==============================
    // word read
    // ==============================
    assign rd_line  = bank_mem[rd_index[`ICACHE_INDEX_W-1 -: `ICACHE_BANK_W]][rd_index[ROW_W-1:0]];
    assign rd_block = rd_way ? rd_line[`ICACHE_LINE_W-1 -: `ICACHE_BLOCK_W]
                             : rd_line[`ICACHE_BLOCK_W-1:0];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (rd_word_hi)
                rd_inst <= rd_block[`ICACHE_BLOCK_W-1 -: `ICACHE_INST_W];
            else
                rd_inst <= rd_block[`ICACHE_INST_W-1:0];
        end
    end

endmodule

//--- rtl/icache_refill.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_refill (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       miss_start,
    input  logic [`ICACHE_ADDR_W-1:0]  miss_addr,
    input  logic                       arready,
    input  icache_pkg::axi_r_t         r,
    output icache_pkg::axi_ar_t        ar,
    output logic                       rready,
    output icache_pkg::fill_t          fill
);

    icache_pkg::refill_state_e  state;
    logic                       arvalid_q;
    logic [`ICACHE_ADDR_W-1:0]  araddr_q;
    logic                       fill_valid_q;
    logic [`ICACHE_BLOCK_W-1:0] fill_data_q;
    logic [`ICACHE_RESP_W-1:0]  fill_resp_q;

    assign ar     = '{valid: arvalid_q, addr: araddr_q};
    assign rready = (state == icache_pkg::REFILL_DATA);
    assign fill   = '{valid: fill_valid_q, addr: araddr_q,
                      data: fill_data_q, resp: fill_resp_q};

    // ==============================
    // read FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= icache_pkg::REFILL_IDLE;
            arvalid_q    <= 1'b0;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= 1'b0;
            case (state)
                icache_pkg::REFILL_IDLE: begin
                    if (miss_start) begin
                        state     <= icache_pkg::REFILL_ADDR;
                        arvalid_q <= 1'b1;
                    end
                end
                icache_pkg::REFILL_ADDR: begin
                    // hold the request until accepted
                    if (arready) begin
                        state     <= icache_pkg::REFILL_DATA;
                        arvalid_q <= 1'b0;
                    end
                end
                icache_pkg::REFILL_DATA: begin
                    if (r.valid) begin
                        state        <= icache_pkg::REFILL_IDLE;
                        fill_valid_q <= 1'b1;
                    end
                end
                default: state <= icache_pkg::REFILL_IDLE;
            endcase
        end
    end

    // address stays put through the fill for the tag and data stores
    always_ff @(posedge clk) begin
        if (state == icache_pkg::REFILL_IDLE && miss_start)
            araddr_q <= miss_addr;
        if (rready && r.valid) begin
            fill_data_q <= r.data;
            fill_resp_q <= r.resp;
        end
    end

    ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr)
    );

    // one beat per block
    r_single_beat: assert property (
        @(posedge clk) disable iff (rst)
        rready && r.valid |-> r.last
    );

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_ADDR_W-1:0]  fetch_pc,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       arready,
    input  icache_pkg::axi_r_t         r,
    output icache_pkg::axi_ar_t        ar,
    output logic                       rready,
    output logic [`ICACHE_INST_W-1:0]  inst,
    output logic                       inst_valid,
    output logic                       error
);

    logic [`ICACHE_ADDR_W-1:0]  lookup_addr;
    icache_pkg::lookup_t        lookup;
    icache_pkg::fill_t          fill;
    logic                       fill_way;
    logic                       miss_start;
    logic [`ICACHE_ADDR_W-1:0]  miss_addr;
    logic                       rd_en;
    logic [`ICACHE_INDEX_W-1:0] rd_index;
    logic                       rd_way;
    logic                       rd_word_hi;
    logic [`ICACHE_INST_W-1:0]  rd_inst;

    icache_fetch_ctrl i_fetch_ctrl (
        .clk, .rst, .fetch_pc, .stall, .flush,
        .lookup, .fill, .rd_inst,
        .lookup_addr, .miss_start, .miss_addr,
        .rd_en, .rd_index, .rd_way, .rd_word_hi,
        .inst, .inst_valid, .error
    );

    icache_tag_store i_tag_store (
        .clk, .rst, .lookup_addr, .fill,
        .lookup, .fill_way
    );

    icache_data_store i_data_store (
        .clk, .fill, .fill_way,
        .rd_en, .rd_index, .rd_way, .rd_word_hi,
        .rd_inst
    );

    icache_refill i_refill (
        .clk, .rst, .miss_start, .miss_addr,
        .arready, .r, .ar, .rready, .fill
    );

endmodule

//--- tb/tb_axi_mem.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module tb_axi_mem (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::axi_ar_t ar,
    input  logic                rready,
    input  logic [3:0]          delays,
    output logic                arready,
    output icache_pkg::axi_r_t  r
);

    logic                      ready_q = 1'b0;
    icache_pkg::axi_r_t        beat_q = '0;
    logic [1:0]                phase = 2'd0;
    logic [1:0]                cnt = 2'd0;
    logic [`ICACHE_ADDR_W-1:0] req_addr = '0;
    logic                      rst_s;
    logic                      arvalid_s;
    logic                      ar_take;
    logic                      r_take;
    logic [`ICACHE_ADDR_W-1:0] addr_s;
    logic [3:0]                dly_s;

    assign arready = ready_q;
    assign r       = beat_q;

    function automatic logic [`ICACHE_INST_W-1:0] word_at(input logic [`ICACHE_ADDR_W-1:0] a);
        return a ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk) begin
        // handshakes as seen at the edge
        rst_s     = rst;
        arvalid_s = ar.valid;
        ar_take   = ar.valid & ready_q;
        r_take    = beat_q.valid & rready;
        addr_s    = ar.addr;
        dly_s     = delays;
        #2;
        if (rst_s) begin
            phase   = 2'd0;
            ready_q = 1'b0;
            beat_q  = '0;
        end else begin
            case (phase)
                2'd0: begin
                    if (arvalid_s) begin
                        cnt   = dly_s[1:0];
                        phase = 2'd1;
                    end
                end
                2'd1: begin
                    if (ar_take) begin
                        ready_q  = 1'b0;
                        req_addr = addr_s;
                        cnt      = dly_s[3:2];
                        phase    = 2'd2;
                    end else if (cnt == 2'd0) begin
                        ready_q = 1'b1;
                    end else begin
                        cnt = cnt - 2'd1;
                    end
                end
                2'd2: begin
                    if (r_take) begin
                        beat_q.valid = 1'b0;
                        phase        = 2'd0;
                    end else if (!beat_q.valid && cnt != 2'd0) begin
                        cnt = cnt - 2'd1;
                    end else if (!beat_q.valid) begin
                        beat_q.valid = 1'b1;
                        beat_q.data  = {word_at(req_addr + 32'd4), word_at(req_addr)};
                        // top nibble F is the error region, SLVERR
                        beat_q.resp  = (req_addr[31:28] == 4'hf) ? 2'b10 : `ICACHE_RESP_OKAY;
                        beat_q.last  = 1'b1;
                    end
                end
                default: phase = 2'd0;
            endcase
        end
    end

endmodule

//--- tb/tb_icache.sv
`timescale 1ns/100ps
`include "icache_defines.svh"

module tb_icache;

    // about a dozen fetches of at most ~16 cycles each, wide margin
    localparam int          MAX_CYCLES = 4000;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic                      clk;
    logic                      rst;
    logic [`ICACHE_ADDR_W-1:0] fetch_pc;
    logic                      stall;
    logic                      flush;
    logic                      arready;
    logic                      rready;
    icache_pkg::axi_ar_t       ar;
    icache_pkg::axi_r_t        r;
    logic [`ICACHE_INST_W-1:0] inst;
    logic                      inst_valid;
    logic                      error;

    logic [31:0]               lfsr = 32'h23b1;
    logic [3:0]                delays = 4'h0;
    logic                      ar_prev = 1'b0;
    logic [`ICACHE_ADDR_W-1:0] ar_last = '0;
    int                        ar_count = 0;
    int                        cycles = 0;
    int                        checks = 0;
    int                        errors = 0;
    int                        base;

    icache_top i_dut (
        .clk, .rst, .fetch_pc, .stall, .flush, .arready, .r,
        .ar, .rready, .inst, .inst_valid, .error
    );

    tb_axi_mem i_mem (.clk, .rst, .ar, .rready, .delays, .arready, .r);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [`ICACHE_INST_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] a);
        return a ^ 32'h5a5a0000;
    endfunction

    // fresh ready delays each cycle, one step per bit
    always @(posedge clk) begin
        #2;
        for (int i = 0; i < 4; i++) begin
            delays = {delays[2:0], lfsr[0]};
            lfsr   = lfsr_step(lfsr);
        end
    end

    always @(posedge clk) begin
        if (ar.valid && !ar_prev) begin
            ar_count = ar_count + 1;
            ar_last  = ar.addr;
        end
        ar_prev = ar.valid;
        cycles  = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_inst(input string name, input logic [`ICACHE_INST_W-1:0] exp,
                              input logic [`ICACHE_INST_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`ICACHE_ADDR_W-1:0] exp,
                              input logic [`ICACHE_ADDR_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_miss(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s: expected %0d read requests, actual %0d", name, exp, act);
        end
    endtask

    // inst_valid sampled just after the edge
    task automatic wait_valid(input logic level);
        @(posedge clk);
        #1;
        while (inst_valid !== level) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fetch(input logic [`ICACHE_ADDR_W-1:0] addr);
        @(posedge clk);
        #2;
        fetch_pc = addr;
        stall    = 1'b0;
        wait_valid(1'b0);
        #1;
        stall = 1'b1;
        wait_valid(1'b1);
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_cold_miss;
        check_inst("reset_inst", `ICACHE_NOP, inst);
        check_flag("reset_valid", 1'b1, inst_valid);
        check_flag("reset_error", 1'b0, error);
        check_flag("reset_arvalid", 1'b0, ar.valid);
        check_flag("reset_rready", 1'b0, rready);
        base = ar_count;
        fetch(32'h80000004);
        check_miss("cold_miss", 1, ar_count - base);
        check_addr("cold_miss", 32'h80000000, ar_last);
        check_inst("cold_miss", mem_word(32'h80000004), inst);
    endtask

    task automatic test_hit;
        base = ar_count;
        fetch(32'h80000000);
        check_inst("hit_low", mem_word(32'h80000000), inst);
        fetch(32'h80000004);
        check_inst("hit_high", mem_word(32'h80000004), inst);
        check_miss("hit", 0, ar_count - base);
    endtask

    task automatic test_replace;
        base = ar_count;
        fetch(32'h10000028);
        fetch(32'h20000028);
        fetch(32'h30000028);
        check_miss("replace_fill", 3, ar_count - base);
        // C took way 0 from A, B still in way 1
        base = ar_count;
        fetch(32'h2000002c);
        check_miss("replace_b_hit", 0, ar_count - base);
        check_inst("replace_b_hit", mem_word(32'h2000002c), inst);
        fetch(32'h10000028);
        check_miss("replace_a_miss", 1, ar_count - base);
        check_inst("replace_a_miss", mem_word(32'h10000028), inst);
    endtask

    task automatic test_flush;
        base = ar_count;
        @(posedge clk);
        #2;
        fetch_pc = 32'h40000010;
        stall    = 1'b0;
        wait_valid(1'b0);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        stall = 1'b1;
        @(posedge clk);
        #1;
        check_inst("flush_nop", `ICACHE_NOP, inst);
        check_flag("flush_valid", 1'b1, inst_valid);
        // the dropped refill still runs through its data beat
        while (rready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        while (rready !== 1'b0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        check_inst("flush_drop", `ICACHE_NOP, inst);
        check_flag("flush_drop_valid", 1'b1, inst_valid);
        fetch(32'h40000010);
        check_miss("flush_refetch", 1, ar_count - base);
        check_inst("flush_refetch", mem_word(32'h40000010), inst);
    endtask

    task automatic test_error;
        fetch(32'hf0000000);
        check_flag("error_set", 1'b1, error);
        fetch(32'h80000100);
        check_flag("error_clear", 1'b0, error);
        check_inst("error_clear", mem_word(32'h80000100), inst);
    endtask

    task automatic test_stall;
        base = ar_count;
        @(posedge clk);
        #2;
        fetch_pc = 32'h12345678;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag("stall_valid", 1'b1, inst_valid);
        end
        check_miss("stall", 0, ar_count - base);
    endtask

    initial begin
        rst      = 1'b1;
        fetch_pc = '0;
        stall    = 1'b1;
        flush    = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        test_cold_miss();
        test_hit();
        test_replace();
        test_flush();
        test_error();
        test_stall();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_fetch_ctrl.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_refill.sv
rtl/icache_top.sv
tb/tb_axi_mem.sv
tb/tb_icache.sv

//--- Makefile
TOP := tb_icache

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee run.log
	@grep -q "^PASS: all tests$$" run.log

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module icache_top

clean:
	rm -rf obj_dir run.log

.PHONY: all run lint clean
